// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       := uart_top_tb
FILELIST  := uart_top.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/uart_bit_timer.sv
`timescale 1ns/1ps

module uart_bit_timer #(
  parameter int CYCLES_PER_BIT = uart_cfg_pkg::UART_CYCLES_PER_BIT_DEF
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_run,      // Count only while a frame is in progress
  input  logic i_restart,  // Reload, phase follows the caller
  input  logic i_half,     // First period only half a bit
  output logic o_tick
);

  localparam int CNT_W = (CYCLES_PER_BIT > 1) ? $clog2(CYCLES_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(CYCLES_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(CYCLES_PER_BIT / 2 - 1);

  logic [CNT_W-1:0] cnt;  // Cycles left in current period

  // Down-counter, reloaded on restart and on every tick
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      cnt <= FULL_LOAD;
    end else if (i_restart) begin
      cnt <= i_half ? HALF_LOAD : FULL_LOAD;  // Half lands on bit centers
    end else if (i_run) begin
      if (cnt == '0) begin
        cnt <= FULL_LOAD;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // Tick on the last cycle of each period
  assign o_tick = i_run && (cnt == '0);

endmodule

// File: hdl/uart_cfg_pkg.sv
package uart_cfg_pkg;

  // ==========================================================================
  // Serial timing
  // ==========================================================================

  // Cycles per serial bit, kept small so simulation stays short
  // A board build overrides this from the PLL rate over the baud rate
  localparam int UART_CYCLES_PER_BIT_DEF = 20;

  // 8N1 frame: start, 8 data, stop
  localparam int UART_FRAME_BITS = 10;

  // ==========================================================================
  // Flow control and checksum
  // ==========================================================================

  // Holding buffer depth in the transmitter
  // Also the credit count the sequencer starts with after reset
  localparam int UART_TX_CREDITS = 2;

  // Running byte sum on the receive side
  localparam int UART_SUM_W = 32;

endpackage

// File: hdl/uart_msg_fsm.sv
`timescale 1ns/1ps

module uart_msg_fsm #(
  parameter bit REPEAT_MSG = 1'b1
) (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_tx_credit,  // One credit back per pulse
  output logic                     o_tx_valid,
  output uart_msg_pkg::uart_byte_t o_tx_data
);

  localparam int IDX_W = (uart_msg_pkg::MSG_LEN > 1) ? $clog2(uart_msg_pkg::MSG_LEN) : 1;
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(uart_msg_pkg::MSG_LEN - 1);
  localparam int CRD_W = $clog2(uart_cfg_pkg::UART_TX_CREDITS + 1);
  localparam logic [CRD_W-1:0] CRD_INIT = CRD_W'(uart_cfg_pkg::UART_TX_CREDITS);

  uart_msg_pkg::msg_state_e state;
  uart_msg_pkg::msg_state_e state_nxt;
  logic [IDX_W-1:0]         msg_idx;     // Next byte to issue
  logic [CRD_W-1:0]         credit_cnt;  // Free slots in the transmitter
  logic [CRD_W-1:0]         credit_nxt;
  logic                     issue;

  // ==========================================================================
  // Issue and credit accounting
  // ==========================================================================

  // Only spend a credit we actually hold
  assign issue      = (state == uart_msg_pkg::SEND) && (credit_cnt != '0);
  assign o_tx_valid = issue;
  assign o_tx_data  = uart_msg_pkg::MSG_BYTES[msg_idx];

  // Valid and credit together cancel out
  assign credit_nxt = credit_cnt - CRD_W'(issue) + CRD_W'(i_tx_credit);

  // ==========================================================================
  // Next state
  // ==========================================================================

  always_comb begin
    state_nxt = state;
    case (state)
      uart_msg_pkg::IDLE: begin
        state_nxt = uart_msg_pkg::SEND;
      end
      uart_msg_pkg::SEND: begin
        if (issue && (msg_idx == IDX_LAST) && !REPEAT_MSG) begin
          state_nxt = uart_msg_pkg::HALT;  // Single shot, last byte gone
        end else if (credit_nxt == '0) begin
          state_nxt = uart_msg_pkg::WAIT;  // Buffer full, stall
        end
      end
      uart_msg_pkg::WAIT: begin
        if (credit_nxt != '0) begin
          state_nxt = uart_msg_pkg::SEND;
        end
      end
      uart_msg_pkg::HALT: begin
        state_nxt = uart_msg_pkg::HALT;
      end
      default: begin
        state_nxt = uart_msg_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state      <= uart_msg_pkg::IDLE;
      msg_idx    <= '0;
      credit_cnt <= CRD_INIT;  // Whole buffer free
    end else begin
      state      <= state_nxt;
      credit_cnt <= credit_nxt;
      if (issue) begin
        // Wrap for the repeat case, harmless when halting
        msg_idx <= (msg_idx == IDX_LAST) ? '0 : msg_idx + 1'b1;
      end
    end
  end

endmodule

// File: hdl/uart_msg_pkg.sv
package uart_msg_pkg;

  // ==========================================================================
  // Payload
  // ==========================================================================

  typedef logic [7:0] uart_byte_t;  // One serial byte

  localparam int MSG_LEN = 8;  // Bytes per message

  // Fixed message "Hi ice40", sent index 0 first
  localparam uart_byte_t MSG_BYTES [MSG_LEN] = '{
    8'h48,  // H
    8'h69,  // i
    8'h20,  // space
    8'h69,  // i
    8'h63,  // c
    8'h65,  // e
    8'h34,  // 4
    8'h30   // 0
  };

  // ==========================================================================
  // Sequencer states
  // ==========================================================================

  typedef enum logic [1:0] {
    IDLE = 2'd0,  // Out of reset, one cycle
    SEND = 2'd1,  // Issuing bytes while credits last
    WAIT = 2'd2,  // No credit, back-pressure from the transmitter
    HALT = 2'd3   // Single message done, parked
  } msg_state_e;

endpackage

// File: hdl/uart_rx_checksum.sv
`timescale 1ns/1ps

module uart_rx_checksum #(
  parameter int CYCLES_PER_BIT = uart_cfg_pkg::UART_CYCLES_PER_BIT_DEF
) (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_serial,
  output uart_msg_pkg::uart_byte_t            o_data,   // Held until next byte
  output logic                                o_valid,
  output logic [uart_cfg_pkg::UART_SUM_W-1:0] o_sum,    // Current message only
  output logic                                o_done
);

  localparam int SUM_W     = uart_cfg_pkg::UART_SUM_W;
  localparam int DATA_BITS = uart_cfg_pkg::UART_FRAME_BITS - 2;
  localparam int BIT_W     = $clog2(DATA_BITS);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DATA_BITS - 1);
  localparam int CNT_W = (uart_msg_pkg::MSG_LEN > 1) ? $clog2(uart_msg_pkg::MSG_LEN) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(uart_msg_pkg::MSG_LEN - 1);

  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,  // Waiting for mid start bit
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_e;

  rx_state_e                state;
  logic [1:0]               sync_q;       // 2-flop synchronizer
  logic                     rx_bit;
  logic                     rx_prev;
  logic                     fall;
  logic                     tick;
  logic                     sum_restart;  // Next byte opens a new message
  logic [BIT_W-1:0]         bit_cnt;
  logic [CNT_W-1:0]         byte_cnt;
  uart_msg_pkg::uart_byte_t shift_q;

  // ==========================================================================
  // Input sync and start edge
  // ==========================================================================

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      sync_q  <= '1;
      rx_prev <= 1'b1;
    end else begin
      sync_q  <= {sync_q[0], i_serial};
      rx_prev <= rx_bit;
    end
  end

  assign rx_bit = sync_q[1];
  assign fall   = rx_prev && !rx_bit;  // High to low, start bit

  uart_bit_timer #(
    .CYCLES_PER_BIT(CYCLES_PER_BIT)
  ) u_bit_timer (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_run    (state != RX_IDLE),
    .i_restart((state == RX_IDLE) && fall),
    .i_half   (1'b1),  // First tick at mid start bit
    .o_tick   (tick)
  );

  // ==========================================================================
  // Frame FSM, sum and message count
  // ==========================================================================

  // Data bits arrive LSB first, shift in from the top
  always_ff @(posedge i_clk) begin
    if ((state == RX_DATA) && tick) begin
      shift_q <= {rx_bit, shift_q[7:1]};
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state       <= RX_IDLE;
      bit_cnt     <= '0;
      byte_cnt    <= '0;
      sum_restart <= 1'b0;
      o_data      <= '0;
      o_valid     <= 1'b0;
      o_sum       <= '0;
      o_done      <= 1'b0;
    end else begin
      o_valid <= 1'b0;
      o_done  <= o_valid && sum_restart;  // Right after the last byte
      case (state)
        RX_IDLE: begin
          if (fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (tick) begin
            bit_cnt <= '0;
            state   <= rx_bit ? RX_IDLE : RX_DATA;  // Glitch, not a start bit
          end
        end
        RX_DATA: begin
          if (tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_LAST) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (tick) begin
            state <= RX_IDLE;
            if (rx_bit) begin  // Good stop, else the frame is dropped
              o_valid <= 1'b1;
              o_data  <= shift_q;
              o_sum   <= sum_restart ? SUM_W'(shift_q) : o_sum + SUM_W'(shift_q);
              if (byte_cnt == CNT_LAST) begin
                byte_cnt    <= '0;
                sum_restart <= 1'b1;  // Final sum holds until next byte
              end else begin
                byte_cnt    <= byte_cnt + 1'b1;
                sum_restart <= 1'b0;
              end
            end
          end
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

endmodule

// File: hdl/uart_top.sv
`timescale 1ns/1ps

module uart_top #(
  parameter int CYCLES_PER_BIT = uart_cfg_pkg::UART_CYCLES_PER_BIT_DEF,
  parameter bit REPEAT_MSG     = 1'b1
) (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  output logic                                o_serial,
  output uart_msg_pkg::uart_byte_t            o_data,
  output logic                                o_valid,
  output logic                                o_done,
  output logic [uart_cfg_pkg::UART_SUM_W-1:0] o_sum
);

  // Sequencer to transmitter, credit flow control
  logic                     tx_valid;
  uart_msg_pkg::uart_byte_t tx_data;
  logic                     tx_credit;

  // ==========================================================================
  // Transmit side
  // ==========================================================================

  uart_msg_fsm #(
    .REPEAT_MSG(REPEAT_MSG)
  ) u_msg_fsm (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_tx_credit(tx_credit),
    .o_tx_valid (tx_valid),
    .o_tx_data  (tx_data)
  );

  uart_tx #(
    .CYCLES_PER_BIT(CYCLES_PER_BIT)
  ) u_tx (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (tx_valid),
    .i_data  (tx_data),
    .o_credit(tx_credit),
    .o_serial(o_serial)
  );

  // ==========================================================================
  // Receive side, looped back on the transmit line
  // ==========================================================================

  uart_rx_checksum #(
    .CYCLES_PER_BIT(CYCLES_PER_BIT)
  ) u_rx (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_serial(o_serial),  // Own TX, no external pin
    .o_data  (o_data),
    .o_valid (o_valid),
    .o_sum   (o_sum),
    .o_done  (o_done)
  );

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int CYCLES_PER_BIT = uart_cfg_pkg::UART_CYCLES_PER_BIT_DEF
) (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_valid,
  input  uart_msg_pkg::uart_byte_t i_data,
  output logic                     o_credit,  // Pulse per byte moved to shifter
  output logic                     o_serial
);

  localparam int DEPTH   = uart_cfg_pkg::UART_TX_CREDITS;
  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W   = $clog2(DEPTH + 1);
  localparam int FRAME_W = uart_cfg_pkg::UART_FRAME_BITS;
  localparam int BIT_W   = $clog2(FRAME_W);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(FRAME_W - 1);

  uart_msg_pkg::uart_byte_t fifo_mem [DEPTH];
  uart_msg_pkg::uart_byte_t load_byte;
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         fifo_cnt;
  logic                     fifo_empty;
  logic                     push;
  logic                     pop;
  logic                     load;       // New frame into the shifter
  logic                     busy;       // Frame on the line
  logic                     tick;
  logic                     frame_end;  // Last tick of the stop bit
  logic [FRAME_W-1:0]       shreg;
  logic [BIT_W-1:0]         bit_cnt;

  // ==========================================================================
  // Holding buffer
  // ==========================================================================

  assign fifo_empty = (fifo_cnt == '0);
  assign frame_end  = tick && (bit_cnt == BIT_LAST);

  // Load when idle or right as the stop bit ends, back to back frames
  assign load = (!busy || frame_end) && (!fifo_empty || i_valid);
  assign pop  = load && !fifo_empty;
  assign push = i_valid && !(load && fifo_empty);  // Empty buffer is bypassed

  assign load_byte = fifo_empty ? i_data : fifo_mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;  // None, or one in one out
      endcase
    end
  end

  // ==========================================================================
  // 8N1 shifter, LSB first
  // ==========================================================================

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      shreg    <= '1;  // Line idles high
      bit_cnt  <= '0;
      busy     <= 1'b0;
      o_credit <= 1'b0;
    end else begin
      o_credit <= load;  // Same cycle the start bit appears
      if (load) begin
        shreg   <= {1'b1, load_byte, 1'b0};  // Stop, data, start
        bit_cnt <= '0;
        busy    <= 1'b1;
      end else if (tick) begin
        shreg <= {1'b1, shreg[FRAME_W-1:1]};  // Fill with idle level
        if (frame_end) begin
          bit_cnt <= '0;
          busy    <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  assign o_serial = shreg[0];

  uart_bit_timer #(
    .CYCLES_PER_BIT(CYCLES_PER_BIT)
  ) u_bit_timer (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_run    (busy),
    .i_restart(load),  // Bit period starts with the frame
    .i_half   (1'b0),
    .o_tick   (tick)
  );

endmodule

// File: testbench/uart_top_checker.sv
`timescale 1ns/1ps

module uart_top_checker (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_tx_valid,   // Sequencer issue
  input logic i_tx_credit,  // Transmitter returns a slot
  input logic i_serial,
  input logic i_valid,
  input logic i_done
);

  logic [3:0] crd_cnt;    // Mirror of the sequencer credit count
  bit         rst_prev;   // Reset was low last cycle
  bit         crd_over;   // Sticky failure flags
  bit         crd_empty;
  bit         out_clash;
  bit         rst_line;
  logic       any_fail;   // Polled by the testbench

  // Wide enough that an extra credit shows up instead of wrapping
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      crd_cnt <= 4'(uart_cfg_pkg::UART_TX_CREDITS);
    end else begin
      crd_cnt <= crd_cnt - 4'(i_tx_valid) + 4'(i_tx_credit);
    end
  end

  always_ff @(posedge i_clk) begin
    rst_prev <= !i_rst_n;
  end

  assign any_fail = crd_over | crd_empty | out_clash | rst_line;

  // ==========================================================================
  // Credit protocol between sequencer and transmitter
  // ==========================================================================

  credit_bounded: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    crd_cnt <= 4'(uart_cfg_pkg::UART_TX_CREDITS)
  ) else begin
    crd_over = 1'b1;
    $error("credit count exceeds the transmitter buffer depth");
  end

  valid_needs_credit: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_tx_valid |-> (crd_cnt != 4'd0)
  ) else begin
    crd_empty = 1'b1;
    $error("tx_valid issued with no credit left");
  end

  // ==========================================================================
  // Receive outputs and line state
  // ==========================================================================

  valid_done_apart: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    !(i_valid && i_done)
  ) else begin
    out_clash = 1'b1;
    $error("o_valid and o_done high in the same cycle");
  end

  // One reset edge needed before the line is defined
  idle_in_reset: assert property (
    @(posedge i_clk)
    (rst_prev && !i_rst_n) |-> i_serial
  ) else begin
    rst_line = 1'b1;
    $error("serial line not idle while reset is held");
  end

endmodule

bind uart_top uart_top_checker u_checker (
  .i_clk      (i_clk),
  .i_rst_n    (i_rst_n),
  .i_tx_valid (tx_valid),
  .i_tx_credit(tx_credit),
  .i_serial   (o_serial),
  .i_valid    (o_valid),
  .i_done     (o_done)
);

// File: testbench/uart_top_tb.sv
`timescale 1ns/1ps

module uart_top_tb;

  localparam int CPB        = uart_cfg_pkg::UART_CYCLES_PER_BIT_DEF;
  localparam int FRAME_CYC  = uart_cfg_pkg::UART_FRAME_BITS * CPB;  // One full frame
  localparam int WAIT_LIMIT = 3 * FRAME_CYC;  // Bound on any byte wait
  localparam int SUM_W      = uart_cfg_pkg::UART_SUM_W;
  localparam int IDX_W      = $clog2(uart_msg_pkg::MSG_LEN);
  localparam int MSG_COUNT  = 2;  // Two full messages

  logic                     i_clk;
  logic                     i_rst_n;
  logic                     o_serial;
  uart_msg_pkg::uart_byte_t o_data;
  logic                     o_valid;
  logic                     o_done;
  logic [SUM_W-1:0]         o_sum;

  uart_top dut0 (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .o_serial(o_serial),
    .o_data  (o_data),
    .o_valid (o_valid),
    .o_done  (o_done),
    .o_sum   (o_sum)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;  // 4 ns period
  end

  // ==========================================================================
  // Reference model
  // ==========================================================================

  function automatic uart_msg_pkg::uart_byte_t msg_byte(input int k);
    logic [IDX_W-1:0] idx;
    idx = IDX_W'(k % uart_msg_pkg::MSG_LEN);  // Message repeats
    return uart_msg_pkg::MSG_BYTES[idx];
  endfunction

  // Sum of the first n message bytes
  function automatic logic [SUM_W-1:0] expected_sum(input int n);
    logic [SUM_W-1:0] sum;
    sum = '0;
    for (int i = 0; i < n; i++) begin
      sum = sum + SUM_W'(msg_byte(i));
    end
    return sum;
  endfunction

  // ==========================================================================
  // Checks and waits
  // ==========================================================================

  task automatic fail_and_stop();
    $display(">>> FAIL");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %0h exp %0h", name, got, exp);
      fail_and_stop();
    end
  endtask

  // Outputs stay at reset values until the first start bit
  task automatic check_idle();
    int cnt;
    cnt = 0;
    while (o_serial !== 1'b0) begin
      if (cnt >= FRAME_CYC) begin
        $display("Timeout: serial line never left idle after reset");
        fail_and_stop();
      end else begin
        check_hex("o_serial", 32'(o_serial), 32'd1);
        check_hex("o_valid", 32'(o_valid), 32'd0);
        check_hex("o_done", 32'(o_done), 32'd0);
        check_hex("o_sum", o_sum, 32'd0);
        check_hex("o_data", 32'(o_data), 32'd0);
        cnt++;
        @(negedge i_clk);
      end
    end
  endtask

  // Held data and sum must not move while waiting
  task automatic wait_for_valid(input logic [31:0] hold_data, input logic [31:0] hold_sum);
    int cnt;
    cnt = 0;
    while (o_valid !== 1'b1) begin
      if (cnt >= WAIT_LIMIT) begin
        $display("Timeout: no received byte within the wait limit");
        fail_and_stop();
      end else begin
        check_hex("o_done", 32'(o_done), 32'd0);
        check_hex("o_data", 32'(o_data), hold_data);
        check_hex("o_sum", o_sum, hold_sum);
        cnt++;
        @(negedge i_clk);
      end
    end
  endtask

  task automatic wait_for_start(input int limit);
    int cnt;
    cnt = 0;
    while (o_serial !== 1'b0) begin
      if (cnt >= limit) begin
        $display("Timeout: no start bit on the serial line");
        fail_and_stop();
      end else begin
        cnt++;
        @(negedge i_clk);
      end
    end
  endtask

  // Every cycle of the frame, each bit exactly CPB cycles wide
  task automatic check_frame(input uart_msg_pkg::uart_byte_t byte_exp);
    logic [9:0] frame_q;
    frame_q = {1'b1, byte_exp, 1'b0};  // Stop, data, start
    for (int b = 0; b < uart_cfg_pkg::UART_FRAME_BITS; b++) begin
      for (int c = 0; c < CPB; c++) begin
        check_hex("o_serial", 32'(o_serial), 32'(frame_q[0]));
        @(negedge i_clk);
      end
      frame_q = frame_q >> 1;
    end
  endtask

  // ==========================================================================
  // Processes
  // ==========================================================================

  // Serial line monitor, frames in message order
  initial begin
    int frame_idx;
    int cnt;
    frame_idx = 0;
    cnt = 0;
    @(negedge i_clk);
    while (i_rst_n !== 1'b1) begin
      if (cnt >= 20) begin
        $display("Timeout: reset never released");
        fail_and_stop();
      end else begin
        cnt++;
        @(negedge i_clk);
      end
    end
    forever begin
      wait_for_start(2 * FRAME_CYC);
      check_frame(msg_byte(frame_idx));
      frame_idx++;
    end
  end

  always @(negedge i_clk) begin
    if (dut0.u_checker.any_fail) begin
      $display("A bound protocol assertion failed");
      fail_and_stop();
    end
  end

  // Reset, then compare every received byte against the model
  initial begin
    logic [31:0] hold_data;
    logic [31:0] hold_sum;
    i_rst_n  = 1'b0;
    repeat (5) @(negedge i_clk);
    i_rst_n = 1'b1;
    check_idle();
    for (int m = 0; m < MSG_COUNT; m++) begin
      for (int b = 0; b < uart_msg_pkg::MSG_LEN; b++) begin
        if (b == 0) begin
          // Previous message stays visible until the first new byte
          hold_data = (m == 0) ? 32'd0 : 32'(msg_byte(uart_msg_pkg::MSG_LEN - 1));
          hold_sum  = (m == 0) ? 32'd0 : expected_sum(uart_msg_pkg::MSG_LEN);
        end else begin
          hold_data = 32'(msg_byte(b - 1));
          hold_sum  = expected_sum(b);
        end
        wait_for_valid(hold_data, hold_sum);
        check_hex("o_data", 32'(o_data), 32'(msg_byte(b)));
        check_hex("o_sum", o_sum, expected_sum(b + 1));
        check_hex("o_done", 32'(o_done), 32'd0);
        @(negedge i_clk);
        check_hex("o_valid", 32'(o_valid), 32'd0);  // Single-cycle pulse
        if (b == uart_msg_pkg::MSG_LEN - 1) begin
          check_hex("o_done", 32'(o_done), 32'd1);
          check_hex("o_sum", o_sum, expected_sum(uart_msg_pkg::MSG_LEN));
          @(negedge i_clk);
        end
      end
    end
    if (!dut0.u_checker.any_fail) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("A bound protocol assertion failed");
      fail_and_stop();
    end
  end

endmodule

// File: uart_top.f
hdl/uart_cfg_pkg.sv
hdl/uart_msg_pkg.sv
hdl/uart_bit_timer.sv
hdl/uart_msg_fsm.sv
hdl/uart_tx.sv
hdl/uart_rx_checksum.sv
hdl/uart_top.sv
testbench/uart_top_checker.sv
testbench/uart_top_tb.sv
